//--- common/decode_pkg.sv
package decode_pkg;

    localparam int WORD_WIDTH    = 16;
    localparam int PC_WIDTH      = 12;
    localparam int REG_IDX_WIDTH = 4;
    localparam int IMM_A_WIDTH   = 4;

    typedef logic [WORD_WIDTH-1:0]    word_t;
    typedef logic [PC_WIDTH-1:0]      pc_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

    // Root opcode in word bits 3..0
    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_U_TYPE = 4'd1,
        OP_J_TYPE = 4'd2,
        OP_S_TYPE = 4'd3,
        OP_LH     = 4'd4,
        OP_ADD    = 4'd6
    } opcode_e;

    // S-type function, bits 7..4
    typedef enum logic [3:0] {
        BEQ  = 4'd0,
        BNEQ = 4'd1,
        BGE  = 4'd2,
        BLT  = 4'd3,
        SH   = 4'd4
    } s_func_e;

    // U-type function, bits 11..8
    typedef enum logic [3:0] {
        LI  = 4'd3,
        LIL = 4'd4
    } u_func_e;

    // J-type function, bits 15..12
    typedef enum logic [3:0] {
        JAL  = 4'd0,
        JALR = 4'd1
    } j_func_e;

    typedef enum logic {
        FIRST_WORD  = 1'b0,
        SECOND_WORD = 1'b1
    } phase_e;

    typedef struct packed {
        logic branch_eq0;
        logic branch_gt0;
        logic branch_lt0;
        logic ialu_add;
        logic ialu_neg_src1;
        logic incr_pc_is_res;
        logic jump_to_ialu_res;
        logic load_dmem;
        logic store_dmem;
        logic write_res_to_reg;
        logic write_src2_to_res;
    } actions_t;

    typedef enum logic [1:0] {
        SRC1_ZERO,
        SRC1_REG1,
        SRC1_IMM_B
    } src1_sel_e;

    typedef enum logic [2:0] {
        SRC2_ZERO,
        SRC2_REG2,
        SRC2_IMM_B,
        SRC2_IMM_A,
        SRC2_PC
    } src2_sel_e;

    typedef enum logic [1:0] {
        SRC3_ZERO,
        SRC3_REG1,
        SRC3_IMM_B
    } src3_sel_e;

    typedef struct packed {
        src1_sel_e src1;
        src2_sel_e src2;
        src3_sel_e src3;
    } operand_sel_t;

    typedef struct packed {
        word_t src1;
        word_t src2;
        word_t src3;  // Branch target or store data
    } operands_t;

    localparam actions_t     ACTIONS_NONE     = '0;
    localparam operand_sel_t OPERAND_SEL_NONE = '{SRC1_ZERO, SRC2_ZERO, SRC3_ZERO};

endpackage

//--- decode/word_sequencer.sv
`timescale 1ns/10ps

module word_sequencer (
    input  logic                clock,
    input  logic                reset,
    input  logic                flush,
    input  decode_pkg::word_t   instr,
    input  decode_pkg::pc_t     pc,
    input  decode_pkg::phase_e  next_phase,
    output logic                flush_q,
    output decode_pkg::word_t   first_word,
    output decode_pkg::word_t   imm_b,
    output decode_pkg::pc_t     instr_pc,
    output decode_pkg::phase_e  phase
);

    decode_pkg::word_t instr_q;
    decode_pkg::pc_t   pc_q;
    decode_pkg::word_t instr_held;  // First word of a two-word instruction
    decode_pkg::pc_t   pc_held;

    // Cleared word decodes as NOP after reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            flush_q <= 1'b0;
            instr_q <= '0;
            phase   <= decode_pkg::FIRST_WORD;
        end else begin
            flush_q <= flush;
            instr_q <= instr;
            phase   <= next_phase;
        end
    end

    always_ff @(posedge clock) begin
        pc_q       <= pc;
        instr_held <= instr_q;
        pc_held    <= pc_q;
    end

    always_comb begin
        if (phase == decode_pkg::SECOND_WORD) begin
            first_word = instr_held;
            instr_pc   = pc_held;
        end else begin
            first_word = instr_q;
            instr_pc   = pc_q;
        end
    end

    assign imm_b = instr_q;  // Only meaningful in second phase

endmodule

//--- decode/control_decoder.sv
`timescale 1ns/10ps

module control_decoder (
    input  decode_pkg::word_t         first_word,
    input  decode_pkg::phase_e        phase,
    input  logic                      flush_q,
    output decode_pkg::actions_t      actions,
    output decode_pkg::operand_sel_t  operand_sel,
    output decode_pkg::word_t         imm_a,
    output decode_pkg::phase_e        next_phase,
    output decode_pkg::reg_idx_t      src1_reg_idx,
    output decode_pkg::reg_idx_t      src2_reg_idx,
    output decode_pkg::reg_idx_t      res_reg_idx
);

    decode_pkg::opcode_e opcode;
    decode_pkg::s_func_e s_func;
    decode_pkg::u_func_e u_func;
    decode_pkg::j_func_e j_func;
    logic                second;

    assign opcode = decode_pkg::opcode_e'(first_word[3:0]);
    assign s_func = decode_pkg::s_func_e'(first_word[7:4]);
    assign u_func = decode_pkg::u_func_e'(first_word[11:8]);
    assign j_func = decode_pkg::j_func_e'(first_word[15:12]);

    assign src1_reg_idx = first_word[11:8];
    assign src2_reg_idx = first_word[15:12];
    assign res_reg_idx  = first_word[7:4];

    assign imm_a = {{(decode_pkg::WORD_WIDTH - decode_pkg::IMM_A_WIDTH){1'b0}},
                    first_word[15:12]};

    assign second = (phase == decode_pkg::SECOND_WORD);

    always_comb begin
        actions     = decode_pkg::ACTIONS_NONE;
        operand_sel = decode_pkg::OPERAND_SEL_NONE;
        next_phase  = decode_pkg::FIRST_WORD;

        // Flush wins over everything and drops a pending second word
        if (!flush_q) begin
            case (opcode)
                decode_pkg::OP_ADD: begin
                    actions.ialu_add         = 1'b1;
                    actions.write_res_to_reg = 1'b1;
                    operand_sel.src1         = decode_pkg::SRC1_REG1;
                    operand_sel.src2         = decode_pkg::SRC2_REG2;
                end

                decode_pkg::OP_LH: begin
                    actions.load_dmem        = 1'b1;
                    actions.write_res_to_reg = 1'b1;
                    operand_sel.src1         = decode_pkg::SRC1_REG1;  // Address
                end

                decode_pkg::OP_U_TYPE: begin
                    case (u_func)
                        decode_pkg::LIL: begin
                            actions.write_res_to_reg  = 1'b1;
                            actions.write_src2_to_res = 1'b1;
                            operand_sel.src2          = decode_pkg::SRC2_IMM_A;
                        end
                        decode_pkg::LI: begin
                            if (second) begin
                                actions.write_res_to_reg  = 1'b1;
                                actions.write_src2_to_res = 1'b1;
                                operand_sel.src2          = decode_pkg::SRC2_IMM_B;
                            end else begin
                                next_phase = decode_pkg::SECOND_WORD;
                            end
                        end
                        default: ;
                    endcase
                end

                decode_pkg::OP_S_TYPE: begin
                    case (s_func)
                        decode_pkg::BEQ, decode_pkg::BNEQ,
                        decode_pkg::BGE, decode_pkg::BLT: begin
                            if (second) begin
                                // Compare as src2 - src1, target in src3
                                actions.ialu_add      = 1'b1;
                                actions.ialu_neg_src1 = 1'b1;
                                actions.branch_eq0    = s_func inside {decode_pkg::BEQ,
                                                                       decode_pkg::BGE};
                                actions.branch_gt0    = s_func inside {decode_pkg::BNEQ,
                                                                       decode_pkg::BGE};
                                actions.branch_lt0    = s_func inside {decode_pkg::BNEQ,
                                                                       decode_pkg::BLT};
                                operand_sel.src1      = decode_pkg::SRC1_REG1;
                                operand_sel.src2      = decode_pkg::SRC2_REG2;
                                operand_sel.src3      = decode_pkg::SRC3_IMM_B;
                            end else begin
                                next_phase = decode_pkg::SECOND_WORD;
                            end
                        end
                        decode_pkg::SH: begin
                            actions.store_dmem        = 1'b1;
                            actions.write_src2_to_res = 1'b1;
                            operand_sel.src2          = decode_pkg::SRC2_REG2;  // Address
                            operand_sel.src3          = decode_pkg::SRC3_REG1;  // Data
                        end
                        default: ;
                    endcase
                end

                decode_pkg::OP_J_TYPE: begin
                    case (j_func)
                        decode_pkg::JALR: begin
                            actions.ialu_add         = 1'b1;
                            actions.incr_pc_is_res   = 1'b1;
                            actions.jump_to_ialu_res = 1'b1;
                            actions.write_res_to_reg = 1'b1;
                            operand_sel.src1         = decode_pkg::SRC1_REG1;
                            operand_sel.src2         = decode_pkg::SRC2_PC;
                        end
                        decode_pkg::JAL: begin
                            if (second) begin
                                actions.ialu_add         = 1'b1;
                                actions.incr_pc_is_res   = 1'b1;
                                actions.jump_to_ialu_res = 1'b1;
                                actions.write_res_to_reg = 1'b1;
                                operand_sel.src1         = decode_pkg::SRC1_IMM_B;
                                operand_sel.src2         = decode_pkg::SRC2_PC;
                            end else begin
                                next_phase = decode_pkg::SECOND_WORD;
                            end
                        end
                        default: ;
                    endcase
                end

                default: ;  // NOP and unknown opcodes
            endcase
        end
    end

endmodule

//--- decode/operand_select.sv
`timescale 1ns/10ps

module operand_select (
    input  decode_pkg::operand_sel_t  operand_sel,
    input  decode_pkg::word_t         reg_data1,
    input  decode_pkg::word_t         reg_data2,
    input  decode_pkg::word_t         imm_a,
    input  decode_pkg::word_t         imm_b,
    input  decode_pkg::pc_t           instr_pc,
    output decode_pkg::operands_t     operands
);

    decode_pkg::word_t pc_word;

    assign pc_word = {{(decode_pkg::WORD_WIDTH - decode_pkg::PC_WIDTH){1'b0}}, instr_pc};

    always_comb begin
        case (operand_sel.src1)
            decode_pkg::SRC1_REG1:  operands.src1 = reg_data1;
            decode_pkg::SRC1_IMM_B: operands.src1 = imm_b;
            default:                operands.src1 = '0;
        endcase
    end

    always_comb begin
        case (operand_sel.src2)
            decode_pkg::SRC2_REG2:  operands.src2 = reg_data2;
            decode_pkg::SRC2_IMM_B: operands.src2 = imm_b;
            decode_pkg::SRC2_IMM_A: operands.src2 = imm_a;
            decode_pkg::SRC2_PC:    operands.src2 = pc_word;  // Return address base
            default:                operands.src2 = '0;
        endcase
    end

    always_comb begin
        case (operand_sel.src3)
            decode_pkg::SRC3_REG1:  operands.src3 = reg_data1;
            decode_pkg::SRC3_IMM_B: operands.src3 = imm_b;
            default:                operands.src3 = '0;
        endcase
    end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   flush,
    input  decode_pkg::word_t      instr,
    input  decode_pkg::pc_t        pc,
    input  decode_pkg::word_t      reg_data1,
    input  decode_pkg::word_t      reg_data2,
    output decode_pkg::reg_idx_t   src1_reg_idx,
    output decode_pkg::reg_idx_t   src2_reg_idx,
    output decode_pkg::reg_idx_t   res_reg_idx,
    output decode_pkg::actions_t   actions,
    output decode_pkg::operands_t  operands
);

    logic                     flush_q;
    decode_pkg::word_t        first_word;
    decode_pkg::word_t        imm_a;
    decode_pkg::word_t        imm_b;
    decode_pkg::pc_t          instr_pc;
    decode_pkg::phase_e       phase;
    decode_pkg::phase_e       next_phase;
    decode_pkg::operand_sel_t operand_sel;

    word_sequencer u_word_sequencer (
        .clock      (clock),
        .reset      (reset),
        .flush      (flush),
        .instr      (instr),
        .pc         (pc),
        .next_phase (next_phase),
        .flush_q    (flush_q),
        .first_word (first_word),
        .imm_b      (imm_b),
        .instr_pc   (instr_pc),
        .phase      (phase)
    );

    control_decoder u_control_decoder (
        .first_word   (first_word),
        .phase        (phase),
        .flush_q      (flush_q),
        .actions      (actions),
        .operand_sel  (operand_sel),
        .imm_a        (imm_a),
        .next_phase   (next_phase),
        .src1_reg_idx (src1_reg_idx),
        .src2_reg_idx (src2_reg_idx),
        .res_reg_idx  (res_reg_idx)
    );

    operand_select u_operand_select (
        .operand_sel (operand_sel),
        .reg_data1   (reg_data1),
        .reg_data2   (reg_data2),
        .imm_a       (imm_a),
        .imm_b       (imm_b),
        .instr_pc    (instr_pc),
        .operands    (operands)
    );

endmodule

//--- test/decode_assertions.sv
`timescale 1ns/10ps

module decode_assertions (
    input logic                 clock,
    input logic                 reset,
    input logic                 flush,
    input decode_pkg::actions_t actions
);

    flush_clears_actions: assert property (@(posedge clock) disable iff (reset)
        flush |=> (actions == '0))
        else $error("actions set in the cycle after a flush");

    load_store_exclusive: assert property (@(posedge clock)
        !(actions.load_dmem && actions.store_dmem))
        else $error("load_dmem and store_dmem set together");

    // First edge in reset clears the registers
    reset_clears_actions: assert property (@(posedge clock)
        (reset && $past(reset)) |-> (actions == '0))
        else $error("actions set while reset is active");

endmodule

bind decode_stage decode_assertions u_decode_assertions (
    .clock   (clock),
    .reset   (reset),
    .flush   (flush),
    .actions (actions)
);

//--- test/decode_checker.sv
`timescale 1ns/10ps

module decode_checker (
    input  logic                  clock,
    input  logic                  check_en,
    input  int                    test_id,
    input  decode_pkg::actions_t  exp_actions,
    input  decode_pkg::word_t     exp_idx_word,
    input  logic [2:0]            exp_use_reg1,  // src1, src2, src3
    input  logic [2:0]            exp_use_reg2,
    input  decode_pkg::operands_t exp_consts,
    input  decode_pkg::word_t     reg_data1,
    input  decode_pkg::word_t     reg_data2,
    input  decode_pkg::reg_idx_t  src1_reg_idx,
    input  decode_pkg::reg_idx_t  src2_reg_idx,
    input  decode_pkg::reg_idx_t  res_reg_idx,
    input  decode_pkg::actions_t  actions,
    input  decode_pkg::operands_t operands,
    output int                    checked_count,
    output int                    failed_count
);

    int checked = 0;
    int failed = 0;
    int mismatches;

    assign checked_count = checked;
    assign failed_count  = failed;

    // Tag lookup against the register data driven this cycle
    function automatic decode_pkg::word_t resolve(input logic from_reg1, input logic from_reg2,
                                                  input decode_pkg::word_t const_value);
        if (from_reg1)
            return reg_data1;
        if (from_reg2)
            return reg_data2;
        return const_value;
    endfunction

    task automatic compare(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
        if (expected !== actual) begin
            $display("FAIL time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            mismatches++;
        end
    endtask

    always @(posedge clock) begin
        #3;  // Just before the next edge
        if (check_en) begin
            mismatches = 0;
            compare("actions", {5'b0, exp_actions}, {5'b0, actions});
            compare("src1", resolve(exp_use_reg1[2], exp_use_reg2[2], exp_consts.src1),
                    operands.src1);
            compare("src2", resolve(exp_use_reg1[1], exp_use_reg2[1], exp_consts.src2),
                    operands.src2);
            compare("src3", resolve(exp_use_reg1[0], exp_use_reg2[0], exp_consts.src3),
                    operands.src3);
            compare("src1_reg_idx", {12'b0, exp_idx_word[11:8]}, {12'b0, src1_reg_idx});
            compare("src2_reg_idx", {12'b0, exp_idx_word[15:12]}, {12'b0, src2_reg_idx});
            compare("res_reg_idx", {12'b0, exp_idx_word[7:4]}, {12'b0, res_reg_idx});
            if (mismatches == 0) begin
                $display("test %0d word %h: ok", test_id, exp_idx_word);
            end else begin
                $display("test %0d word %h: %0d mismatches", test_id, exp_idx_word, mismatches);
                failed++;
            end
            checked++;
        end
    end

endmodule

//--- test/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb;

    typedef struct packed {
        logic                  flush;
        decode_pkg::word_t     instr;
        decode_pkg::pc_t       pc;
        decode_pkg::actions_t  actions;
        decode_pkg::word_t     idx_word;  // First word, source of the register indices
        logic [2:0]            use_reg1;  // Per operand, src1 in bit 2
        logic [2:0]            use_reg2;
        decode_pkg::operands_t consts;
    } row_t;

    logic                  clock;
    logic                  reset;
    logic                  flush;
    decode_pkg::word_t     instr;
    decode_pkg::pc_t       pc;
    decode_pkg::word_t     reg_data1;
    decode_pkg::word_t     reg_data2;
    decode_pkg::reg_idx_t  src1_reg_idx;
    decode_pkg::reg_idx_t  src2_reg_idx;
    decode_pkg::reg_idx_t  res_reg_idx;
    decode_pkg::actions_t  actions;
    decode_pkg::operands_t operands;

    logic                  check_en;
    int                    test_id;
    decode_pkg::actions_t  exp_actions;
    decode_pkg::word_t     exp_idx_word;
    logic [2:0]            exp_use_reg1;
    logic [2:0]            exp_use_reg2;
    decode_pkg::operands_t exp_consts;
    int                    checked_count;
    int                    failed_count;

    row_t   rows[$];
    integer seed = 32'h6434_b23a;
    logic   timed_out;
    int     cycles;

    decode_stage uut (.*);

    decode_checker u_checker (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;
    end

    task automatic add_row(input logic row_flush, input decode_pkg::word_t row_instr,
                           input decode_pkg::pc_t row_pc, input decode_pkg::actions_t row_actions,
                           input decode_pkg::word_t row_idx_word, input logic [2:0] row_reg1,
                           input logic [2:0] row_reg2, input decode_pkg::word_t c1,
                           input decode_pkg::word_t c2, input decode_pkg::word_t c3);
        row_t r;
        r.flush       = row_flush;
        r.instr       = row_instr;
        r.pc          = row_pc;
        r.actions     = row_actions;
        r.idx_word    = row_idx_word;
        r.use_reg1    = row_reg1;
        r.use_reg2    = row_reg2;
        r.consts.src1 = c1;
        r.consts.src2 = c2;
        r.consts.src3 = c3;
        rows.push_back(r);
    endtask

    task automatic build_table();
        decode_pkg::actions_t a_none, a_add, a_lh, a_sh, a_imm, a_jump, a_beq, a_bneq, a_bge, a_blt;
        a_none = '0;
        a_add  = '{ialu_add: 1'b1, write_res_to_reg: 1'b1, default: 1'b0};
        a_lh   = '{load_dmem: 1'b1, write_res_to_reg: 1'b1, default: 1'b0};
        a_sh   = '{store_dmem: 1'b1, write_src2_to_res: 1'b1, default: 1'b0};
        a_imm  = '{write_res_to_reg: 1'b1, write_src2_to_res: 1'b1, default: 1'b0};
        a_jump = '{ialu_add: 1'b1, incr_pc_is_res: 1'b1, jump_to_ialu_res: 1'b1,
                   write_res_to_reg: 1'b1, default: 1'b0};
        a_beq  = '{ialu_add: 1'b1, ialu_neg_src1: 1'b1, default: 1'b0};  // src2 - src1
        a_bneq = a_beq;
        a_bge  = a_beq;
        a_blt  = a_beq;
        a_beq.branch_eq0  = 1'b1;
        a_bneq.branch_gt0 = 1'b1;
        a_bneq.branch_lt0 = 1'b1;
        a_bge.branch_eq0  = 1'b1;
        a_bge.branch_gt0  = 1'b1;
        a_blt.branch_lt0  = 1'b1;

        // flush instr pc actions idx_word use_reg1 use_reg2 src1 src2 src3
        add_row(1'b0, 16'h0000, 12'h000, a_none, 16'h0000, 3'b000, 3'b000, 16'h0, 16'h0, 16'h0);
        add_row(1'b0, 16'h7356, 12'h002, a_add, 16'h7356, 3'b100, 3'b010, 16'h0, 16'h0, 16'h0);
        add_row(1'b0, 16'hA294, 12'h003, a_lh, 16'hA294, 3'b100, 3'b000, 16'h0, 16'h0, 16'h0);
        add_row(1'b0, 16'hB643, 12'h004, a_sh, 16'hB643, 3'b001, 3'b010, 16'h0, 16'h0, 16'h0);
        add_row(1'b0, 16'h18E2, 12'h3A5, a_jump, 16'h18E2, 3'b100, 3'b000, 16'h0, 16'h03A5, 16'h0);
        add_row(1'b0, 16'hD421, 12'h006, a_imm, 16'hD421, 3'b000, 3'b000, 16'h0, 16'h000D, 16'h0);
        // LI, then its immediate word
        add_row(1'b0, 16'h5361, 12'h007, a_none, 16'h5361, 3'b000, 3'b000, 16'h0, 16'h0, 16'h0);
        add_row(1'b0, 16'hBEEF, 12'h008, a_imm, 16'h5361, 3'b000, 3'b000, 16'h0, 16'hBEEF, 16'h0);
        add_row(1'b0, 16'h4203, 12'h009, a_none, 16'h4203, 3'b000, 3'b000, 16'h0, 16'h0, 16'h0);
        add_row(1'b0, 16'h0123, 12'h00A, a_beq, 16'h4203, 3'b100, 3'b010, 16'h0, 16'h0, 16'h0123);
        add_row(1'b0, 16'h6513, 12'h00B, a_none, 16'h6513, 3'b000, 3'b000, 16'h0, 16'h0, 16'h0);
        add_row(1'b0, 16'h0F00, 12'h00C, a_bneq, 16'h6513, 3'b100, 3'b010, 16'h0, 16'h0, 16'h0F00);
        add_row(1'b0, 16'h9823, 12'h00D, a_none, 16'h9823, 3'b000, 3'b000, 16'h0, 16'h0, 16'h0);
        add_row(1'b0, 16'h7FFE, 12'h00E, a_bge, 16'h9823, 3'b100, 3'b010, 16'h0, 16'h0, 16'h7FFE);
        add_row(1'b0, 16'hC133, 12'h00F, a_none, 16'hC133, 3'b000, 3'b000, 16'h0, 16'h0, 16'h0);
        add_row(1'b0, 16'h8001, 12'h010, a_blt, 16'hC133, 3'b100, 3'b010, 16'h0, 16'h0, 16'h8001);
        // JAL returns the PC of its first word
        add_row(1'b0, 16'h07F2, 12'h444, a_none, 16'h07F2, 3'b000, 3'b000, 16'h0, 16'h0, 16'h0);
        add_row(1'b0, 16'h1234, 12'h445, a_jump, 16'h07F2, 3'b000, 3'b000, 16'h1234, 16'h0444, 16'h0);
        add_row(1'b1, 16'h4203, 12'h013, a_none, 16'h4203, 3'b000, 3'b000, 16'h0, 16'h0, 16'h0);
        add_row(1'b0, 16'h7356, 12'h014, a_add, 16'h7356, 3'b100, 3'b010, 16'h0, 16'h0, 16'h0);
        add_row(1'b0, 16'h345F, 12'h015, a_none, 16'h345F, 3'b000, 3'b000, 16'h0, 16'h0, 16'h0);
        add_row(1'b0, 16'h1293, 12'h016, a_none, 16'h1293, 3'b000, 3'b000, 16'h0, 16'h0, 16'h0);
        // Flush on a one-word instruction
        add_row(1'b1, 16'h7356, 12'h017, a_none, 16'h7356, 3'b000, 3'b000, 16'h0, 16'h0, 16'h0);
    endtask

    initial begin
        flush        = 1'b0;
        instr        = 16'h7356;  // ADD word held through reset
        pc           = '0;
        reg_data1    = '0;
        reg_data2    = '0;
        check_en     = 1'b0;
        test_id      = 0;
        exp_actions  = '0;
        exp_idx_word = '0;
        exp_use_reg1 = '0;
        exp_use_reg2 = '0;
        exp_consts   = '0;
        timed_out    = 1'b0;
        build_table();

        cycles = 0;
        do begin
            @(posedge clock or negedge reset);
            cycles++;
        end while (reset && cycles < 20);

        if (reset) begin
            timed_out = 1'b1;
            $display("Timeout: reset was never released");
        end else begin
            instr = '0;
            @(posedge clock);
            // Row i goes in while the DUT shows row i-1
            for (int i = 0; i <= rows.size(); i++) begin
                #1;
                if (i < rows.size()) begin
                    flush = rows[i].flush;
                    instr = rows[i].instr;
                    pc    = rows[i].pc;
                end else begin
                    flush = 1'b0;
                    instr = '0;
                    pc    = '0;
                end
                reg_data1 = 16'($random(seed));
                reg_data2 = 16'($random(seed));
                check_en  = (i > 0);
                if (i > 0) begin
                    test_id      = i - 1;
                    exp_actions  = rows[i-1].actions;
                    exp_idx_word = rows[i-1].idx_word;
                    exp_use_reg1 = rows[i-1].use_reg1;
                    exp_use_reg2 = rows[i-1].use_reg2;
                    exp_consts   = rows[i-1].consts;
                end
                @(posedge clock);
            end
            #1 check_en = 1'b0;

            cycles = 0;
            while (checked_count < rows.size() && cycles < 10) begin
                @(posedge clock);
                cycles++;
            end
            if (checked_count < rows.size()) begin
                timed_out = 1'b1;
                $display("Timeout: checker finished only %0d of %0d tests",
                         checked_count, rows.size());
            end
        end

        $display("tests=%0d failed=%0d", checked_count, failed_count);
        if (!timed_out && failed_count == 0 && checked_count == rows.size())
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- sources.f
common/decode_pkg.sv
decode/word_sequencer.sv
decode/control_decoder.sv
decode/operand_select.sv
hw/decode_stage.sv
test/decode_assertions.sv
test/decode_checker.sv
test/decode_stage_tb.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f --top-module decode_stage_tb \
        -Mdir obj_dir -o decode_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/decode_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
echo "Pass message not found"
exit 1
